/* logic/llr_pkg.sv */
package llr_pkg;

    // ----------------------------
    // symbol stream
    // ----------------------------

    // one I or Q component, symbol is {imag, real}
    localparam int IQ_DW      = 16;
    localparam int SYM_TYPE_W = 2;

    localparam logic [SYM_TYPE_W-1:0] SYM_PBCH = 2'd1;

    // ----------------------------
    // AXI4-Lite register map
    // ----------------------------

    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;

    localparam logic [AXIL_ADDR_W-1:0] REG_DATA  = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] REG_LEVEL = 4'h4;
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL  = 4'h8;
    localparam logic [AXIL_ADDR_W-1:0] REG_DROPS = 4'hC;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* logic/llr_demap.sv */
module llr_demap #(
    parameter int LLR_DW = 8
) (
    input  logic                           clk_i,
    input  logic                           reset_ni,

    input  logic [2*llr_pkg::IQ_DW-1:0]    sym_data_i,
    input  logic [llr_pkg::SYM_TYPE_W-1:0] sym_type_i,
    input  logic                           sym_last_i,
    input  logic                           sym_valid_i,

    output logic [2*LLR_DW-1:0]            pair_data_o,
    output logic                           pair_last_o,
    output logic                           pair_valid_o
);
    import llr_pkg::*;

    logic [LLR_DW-1:0] llr_re;
    logic [LLR_DW-1:0] llr_im;

    // top bits of each component, sign kept
    assign llr_re = sym_data_i[IQ_DW-1 -: LLR_DW];
    assign llr_im = sym_data_i[2*IQ_DW-1 -: LLR_DW];

    // only PBCH symbols go on to the store
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pair_valid_o <= 1'b0;
        end else begin
            pair_valid_o <= sym_valid_i && (sym_type_i == SYM_PBCH);
        end
    end

    always_ff @(posedge clk_i) begin
        if (sym_valid_i) begin
            pair_data_o <= {llr_im, llr_re};
            pair_last_o <= sym_last_i;
        end
    end

endmodule

/* logic/llr_fifo.sv */
module llr_fifo #(
    parameter int LLR_DW     = 8,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                            clk_i,
    input  logic                            reset_ni,

    input  logic [2*LLR_DW:0]               wr_data_i,
    input  logic                            wr_valid_i,
    input  logic                            pop_i,
    input  logic                            clear_i,

    output logic [2*LLR_DW:0]               rd_data_o,
    output logic [$clog2(FIFO_DEPTH):0]     level_o,
    output logic [15:0]                     drops_o
);
    localparam int ENTRY_W = 2*LLR_DW + 1;
    localparam int PTR_W   = $clog2(FIFO_DEPTH);
    localparam int LVL_W   = PTR_W + 1;

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [LVL_W-1:0]   count;
    logic               full;
    logic               push;

    assign full = (count == LVL_W'(FIFO_DEPTH));

    // a pop in the same cycle frees the slot
    assign push = wr_valid_i && (!full || pop_i);

    assign rd_data_o = mem[rd_ptr];
    assign level_o   = count;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni || clear_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            drops_o <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // overflow drop count, saturates
            if (wr_valid_i && !push && (drops_o != '1)) begin
                drops_o <= drops_o + 1'b1;
            end
        end
    end

endmodule

/* logic/llr_axil_regs.sv */
module llr_axil_regs #(
    parameter int LLR_DW     = 8,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                              clk_i,
    input  logic                              reset_ni,

    input  logic [llr_pkg::AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
    input  logic                              s_axil_awvalid_i,
    output logic                              s_axil_awready_o,
    input  logic [llr_pkg::AXIL_DATA_W-1:0]   s_axil_wdata_i,
    input  logic [llr_pkg::AXIL_DATA_W/8-1:0] s_axil_wstrb_i,
    input  logic                              s_axil_wvalid_i,
    output logic                              s_axil_wready_o,
    output logic [1:0]                        s_axil_bresp_o,
    output logic                              s_axil_bvalid_o,
    input  logic                              s_axil_bready_i,
    input  logic [llr_pkg::AXIL_ADDR_W-1:0]   s_axil_araddr_i,
    input  logic                              s_axil_arvalid_i,
    output logic                              s_axil_arready_o,
    output logic [llr_pkg::AXIL_DATA_W-1:0]   s_axil_rdata_o,
    output logic [1:0]                        s_axil_rresp_o,
    output logic                              s_axil_rvalid_o,
    input  logic                              s_axil_rready_i,

    input  logic [2*LLR_DW:0]                 fifo_data_i,
    input  logic [$clog2(FIFO_DEPTH):0]       fifo_level_i,
    input  logic [15:0]                       fifo_drops_i,
    output logic                              pop_o,
    output logic                              clear_o
);
    import llr_pkg::*;

    localparam int ENTRY_W = 2*LLR_DW + 1;
    localparam int LVL_W   = $clog2(FIFO_DEPTH) + 1;

    logic                   wr_accept;
    logic                   wr_to_ctrl;
    logic                   rd_accept;
    logic                   fifo_empty;
    logic [AXIL_DATA_W-1:0] rd_value;
    logic [1:0]             rd_resp;

    // ----------------------------
    // write path
    // ----------------------------

    // wstrb ignored, full word writes only
    assign wr_accept  = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o;
    assign wr_to_ctrl = (s_axil_awaddr_i == REG_CTRL);

    assign s_axil_awready_o = wr_accept;
    assign s_axil_wready_o  = wr_accept;

    assign clear_o = wr_accept && wr_to_ctrl && s_axil_wdata_i[0];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            s_axil_bvalid_o <= 1'b0;
        end else if (wr_accept) begin
            s_axil_bvalid_o <= 1'b1;
        end else if (s_axil_bready_i) begin
            s_axil_bvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_accept) begin
            s_axil_bresp_o <= wr_to_ctrl ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // ----------------------------
    // read path
    // ----------------------------

    assign rd_accept  = s_axil_arvalid_i && !s_axil_rvalid_o;
    assign fifo_empty = (fifo_level_i == '0);

    assign s_axil_arready_o = rd_accept;

    // empty data read pops nothing
    assign pop_o = rd_accept && (s_axil_araddr_i == REG_DATA) && !fifo_empty;

    always_comb begin
        rd_value = '0;
        rd_resp  = RESP_OKAY;
        case (s_axil_araddr_i)
            REG_DATA: begin
                if (!fifo_empty) begin
                    rd_value = {{(AXIL_DATA_W-ENTRY_W){1'b0}}, fifo_data_i};
                end
            end
            REG_LEVEL: rd_value = {{(AXIL_DATA_W-LVL_W){1'b0}}, fifo_level_i};
            // write only, reads back zero
            REG_CTRL:  rd_value = '0;
            REG_DROPS: rd_value = {{(AXIL_DATA_W-16){1'b0}}, fifo_drops_i};
            default:   rd_resp  = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            s_axil_rvalid_o <= 1'b0;
        end else if (rd_accept) begin
            s_axil_rvalid_o <= 1'b1;
        end else if (s_axil_rready_i) begin
            s_axil_rvalid_o <= 1'b0;
        end
    end

    // held until rready, sampled at acceptance
    always_ff @(posedge clk_i) begin
        if (rd_accept) begin
            s_axil_rdata_o <= rd_value;
            s_axil_rresp_o <= rd_resp;
        end
    end

endmodule

/* logic/pbch_llr_capture.sv */
module pbch_llr_capture #(
    parameter int LLR_DW     = 8,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                              clk_i,
    input  logic                              reset_ni,

    input  logic [2*llr_pkg::IQ_DW-1:0]       sym_data_i,
    input  logic [llr_pkg::SYM_TYPE_W-1:0]    sym_type_i,
    input  logic                              sym_last_i,
    input  logic                              sym_valid_i,

    input  logic [llr_pkg::AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
    input  logic                              s_axil_awvalid_i,
    output logic                              s_axil_awready_o,
    input  logic [llr_pkg::AXIL_DATA_W-1:0]   s_axil_wdata_i,
    input  logic [llr_pkg::AXIL_DATA_W/8-1:0] s_axil_wstrb_i,
    input  logic                              s_axil_wvalid_i,
    output logic                              s_axil_wready_o,
    output logic [1:0]                        s_axil_bresp_o,
    output logic                              s_axil_bvalid_o,
    input  logic                              s_axil_bready_i,
    input  logic [llr_pkg::AXIL_ADDR_W-1:0]   s_axil_araddr_i,
    input  logic                              s_axil_arvalid_i,
    output logic                              s_axil_arready_o,
    output logic [llr_pkg::AXIL_DATA_W-1:0]   s_axil_rdata_o,
    output logic [1:0]                        s_axil_rresp_o,
    output logic                              s_axil_rvalid_o,
    input  logic                              s_axil_rready_i
);
    localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

    logic [2*LLR_DW-1:0] pair_data;
    logic                pair_last;
    logic                pair_valid;
    logic [2*LLR_DW:0]   rd_data;
    logic [LVL_W-1:0]    level;
    logic [15:0]         drops;
    logic                pop;
    logic                clear;

    // ----------------------------
    // demapper and PBCH filter
    // ----------------------------

    llr_demap #(
        .LLR_DW(LLR_DW)
    ) u_llr_demap (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .sym_data_i(sym_data_i),
        .sym_type_i(sym_type_i),
        .sym_last_i(sym_last_i),
        .sym_valid_i(sym_valid_i),
        .pair_data_o(pair_data),
        .pair_last_o(pair_last),
        .pair_valid_o(pair_valid)
    );

    // ----------------------------
    // LLR store
    // ----------------------------

    // last flag above the pair
    llr_fifo #(
        .LLR_DW(LLR_DW),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_llr_fifo (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .wr_data_i({pair_last, pair_data}),
        .wr_valid_i(pair_valid),
        .pop_i(pop),
        .clear_i(clear),
        .rd_data_o(rd_data),
        .level_o(level),
        .drops_o(drops)
    );

    // ----------------------------
    // register access
    // ----------------------------

    llr_axil_regs #(
        .LLR_DW(LLR_DW),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_llr_axil_regs (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .s_axil_awaddr_i(s_axil_awaddr_i),
        .s_axil_awvalid_i(s_axil_awvalid_i),
        .s_axil_awready_o(s_axil_awready_o),
        .s_axil_wdata_i(s_axil_wdata_i),
        .s_axil_wstrb_i(s_axil_wstrb_i),
        .s_axil_wvalid_i(s_axil_wvalid_i),
        .s_axil_wready_o(s_axil_wready_o),
        .s_axil_bresp_o(s_axil_bresp_o),
        .s_axil_bvalid_o(s_axil_bvalid_o),
        .s_axil_bready_i(s_axil_bready_i),
        .s_axil_araddr_i(s_axil_araddr_i),
        .s_axil_arvalid_i(s_axil_arvalid_i),
        .s_axil_arready_o(s_axil_arready_o),
        .s_axil_rdata_o(s_axil_rdata_o),
        .s_axil_rresp_o(s_axil_rresp_o),
        .s_axil_rvalid_o(s_axil_rvalid_o),
        .s_axil_rready_i(s_axil_rready_i),
        .fifo_data_i(rd_data),
        .fifo_level_i(level),
        .fifo_drops_i(drops),
        .pop_o(pop),
        .clear_o(clear)
    );

endmodule

/* verification/tb_axil_tasks.svh */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// single AXI4-Lite write, returns bresp
task automatic write_reg(input logic [AXIL_ADDR_W-1:0] addr,
                         input logic [AXIL_DATA_W-1:0] data,
                         output logic [1:0] resp);
    bit accepted;
    accepted = 1'b0;
    @(posedge clk_i);
    #1;
    s_axil_awaddr_i  = addr;
    s_axil_wdata_i   = data;
    s_axil_awvalid_i = 1'b1;
    s_axil_wvalid_i  = 1'b1;
    while (!accepted) begin
        #1;
        accepted = s_axil_awready_o;
        // both ready strobes pulse in the acceptance cycle
        if (accepted) begin
            expect_equal("s_axil_wready_o", 32'(s_axil_wready_o), 32'd1);
        end
        @(posedge clk_i);
        #1;
    end
    s_axil_awvalid_i = 1'b0;
    s_axil_wvalid_i  = 1'b0;
    while (!s_axil_bvalid_o) begin
        @(posedge clk_i);
        #1;
    end
    resp = s_axil_bresp_o;
    s_axil_bready_i = 1'b1;
    @(posedge clk_i);
    #1;
    s_axil_bready_i = 1'b0;
endtask

// single AXI4-Lite read, rready held low for stall cycles
task automatic read_reg(input logic [AXIL_ADDR_W-1:0] addr,
                        input int stall,
                        output logic [AXIL_DATA_W-1:0] data,
                        output logic [1:0] resp);
    bit accepted;
    accepted = 1'b0;
    @(posedge clk_i);
    #1;
    s_axil_araddr_i  = addr;
    s_axil_arvalid_i = 1'b1;
    while (!accepted) begin
        #1;
        accepted = s_axil_arready_o;
        @(posedge clk_i);
        #1;
    end
    s_axil_arvalid_i = 1'b0;
    while (!s_axil_rvalid_o) begin
        @(posedge clk_i);
        #1;
    end
    data = s_axil_rdata_o;
    resp = s_axil_rresp_o;
    // response must hold while the master stalls
    for (int i = 0; i < stall; i++) begin
        @(posedge clk_i);
        #1;
        expect_equal("s_axil_rvalid_o", 32'(s_axil_rvalid_o), 32'd1);
        expect_equal("s_axil_rdata_o", s_axil_rdata_o, data);
    end
    s_axil_rready_i = 1'b1;
    @(posedge clk_i);
    #1;
    s_axil_rready_i = 1'b0;
endtask

`endif

/* verification/pbch_llr_capture_tb.sv */
module pbch_llr_capture_tb;
    import llr_pkg::*;

    localparam int LLR_DW     = 8;
    localparam int FIFO_DEPTH = 16;
    localparam int ENTRY_W    = 2*LLR_DW + 1;
    localparam int ROUNDS     = 4;
    localparam int BURST_LEN  = 2*FIFO_DEPTH;
    localparam int OVF_EXTRA  = 5;
    // several times the length of all tests together
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] LFSR_SEED = 32'h302989fa;

    logic                     clk_i = 1'b0;
    logic                     reset_ni;
    logic [2*IQ_DW-1:0]       sym_data_i;
    logic [SYM_TYPE_W-1:0]    sym_type_i;
    logic                     sym_last_i;
    logic                     sym_valid_i;
    logic [AXIL_ADDR_W-1:0]   s_axil_awaddr_i;
    logic                     s_axil_awvalid_i;
    logic                     s_axil_awready_o;
    logic [AXIL_DATA_W-1:0]   s_axil_wdata_i;
    logic [AXIL_DATA_W/8-1:0] s_axil_wstrb_i;
    logic                     s_axil_wvalid_i;
    logic                     s_axil_wready_o;
    logic [1:0]               s_axil_bresp_o;
    logic                     s_axil_bvalid_o;
    logic                     s_axil_bready_i;
    logic [AXIL_ADDR_W-1:0]   s_axil_araddr_i;
    logic                     s_axil_arvalid_i;
    logic                     s_axil_arready_o;
    logic [AXIL_DATA_W-1:0]   s_axil_rdata_o;
    logic [1:0]               s_axil_rresp_o;
    logic                     s_axil_rvalid_o;
    logic                     s_axil_rready_i;

    logic [31:0]        lfsr_state  = LFSR_SEED;
    logic [ENTRY_W-1:0] model_q[$];
    logic [15:0]        model_drops = '0;
    int                 check_count = 0;
    int                 error_count = 0;
    int                 cycle_count = 0;
    logic [31:0]        rd_word;
    logic [1:0]         resp;

    pbch_llr_capture #(
        .LLR_DW(LLR_DW),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_pbch_llr_capture (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic void expect_equal(input string name, input logic [31:0] got,
                                         input logic [31:0] want);
        check_count++;
        assert (got === want)
        else begin
            error_count++;
            $display("Fail %s at %0t: got 0x%08h expected 0x%08h", name, $time, got, want);
        end
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic void store_model_entry(input logic [ENTRY_W-1:0] entry);
        if (model_q.size() < FIFO_DEPTH) begin
            model_q.push_back(entry);
        end else if (model_drops != 16'hffff) begin
            model_drops++;
        end
    endfunction

    `include "tb_axil_tasks.svh"

    task automatic send_symbols(input int n, input bit pbch_only);
        logic [2*IQ_DW-1:0]    data;
        logic [SYM_TYPE_W-1:0] typ;
        logic                  last;
        logic [LLR_DW-1:0]     re_llr;
        logic [LLR_DW-1:0]     im_llr;
        for (int i = 0; i < n; i++) begin
            data = take_bits(2*IQ_DW);
            typ  = pbch_only ? SYM_PBCH : SYM_TYPE_W'(take_bits(SYM_TYPE_W));
            last = 1'(take_bits(1));
            @(posedge clk_i);
            #1;
            sym_data_i  = data;
            sym_type_i  = typ;
            sym_last_i  = last;
            sym_valid_i = 1'b1;
            // floor of value / 2^(IQ_DW-LLR_DW), two's complement kept
            re_llr = LLR_DW'(data[IQ_DW-1:0] >> (IQ_DW - LLR_DW));
            im_llr = LLR_DW'(data[2*IQ_DW-1:IQ_DW] >> (IQ_DW - LLR_DW));
            if (typ == SYM_PBCH) begin
                store_model_entry({last, im_llr, re_llr});
            end
        end
        @(posedge clk_i);
        #1;
        sym_valid_i = 1'b0;
        // demapper plus FIFO latency before the level counts it
        repeat (3) @(posedge clk_i);
    endtask

    task automatic clear_fifo();
        logic [1:0] r;
        write_reg(REG_CTRL, 32'h1, r);
        expect_equal("s_axil_bresp_o", 32'(r), 32'(RESP_OKAY));
        model_q.delete();
        model_drops = '0;
    endtask

    task automatic check_reg(input string name, input logic [AXIL_ADDR_W-1:0] addr,
                             input logic [31:0] want);
        logic [31:0] d;
        logic [1:0]  r;
        read_reg(addr, 0, d, r);
        expect_equal(name, d, want);
        expect_equal("s_axil_rresp_o", 32'(r), 32'(RESP_OKAY));
    endtask

    task automatic drain_and_check();
        logic [31:0] d;
        logic [1:0]  r;
        while (model_q.size() > 0) begin
            read_reg(REG_DATA, 0, d, r);
            expect_equal("s_axil_rdata_o", d, 32'(model_q.pop_front()));
            expect_equal("s_axil_rresp_o", 32'(r), 32'(RESP_OKAY));
        end
        // empty store reads zero
        check_reg("s_axil_rdata_o", REG_DATA, 32'd0);
    endtask

    initial begin
        reset_ni         = 1'b0;
        sym_data_i       = '0;
        sym_type_i       = '0;
        sym_last_i       = 1'b0;
        sym_valid_i      = 1'b0;
        s_axil_awaddr_i  = '0;
        s_axil_awvalid_i = 1'b0;
        s_axil_wdata_i   = '0;
        s_axil_wstrb_i   = '1;
        s_axil_wvalid_i  = 1'b0;
        s_axil_bready_i  = 1'b0;
        s_axil_araddr_i  = '0;
        s_axil_arvalid_i = 1'b0;
        s_axil_rready_i  = 1'b0;
        repeat (16) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;
        @(posedge clk_i);
        #1;

        // ------------------------------
        expect_equal("s_axil_bvalid_o", 32'(s_axil_bvalid_o), 32'd0);
        expect_equal("s_axil_rvalid_o", 32'(s_axil_rvalid_o), 32'd0);
        expect_equal("s_axil_awready_o", 32'(s_axil_awready_o), 32'd0);
        expect_equal("s_axil_arready_o", 32'(s_axil_arready_o), 32'd0);
        check_reg("level", REG_LEVEL, 32'd0);
        check_reg("drops", REG_DROPS, 32'd0);

        // mixed traffic, only PBCH is stored
        for (int r = 0; r < ROUNDS; r++) begin
            send_symbols(BURST_LEN, 1'b0);
            check_reg("level", REG_LEVEL, 32'(model_q.size()));
            check_reg("drops", REG_DROPS, 32'(model_drops));
            drain_and_check();
        end

        // ------------------------------
        clear_fifo();
        send_symbols(FIFO_DEPTH + OVF_EXTRA, 1'b1);
        check_reg("level", REG_LEVEL, 32'(FIFO_DEPTH));
        check_reg("drops", REG_DROPS, 32'(OVF_EXTRA));
        drain_and_check();

        send_symbols(FIFO_DEPTH + 2, 1'b1);
        clear_fifo();
        check_reg("level", REG_LEVEL, 32'd0);
        check_reg("drops", REG_DROPS, 32'd0);
        write_reg(REG_DATA, 32'h1, resp);
        expect_equal("s_axil_bresp_o", 32'(resp), 32'(RESP_SLVERR));
        write_reg(REG_DROPS, 32'h1, resp);
        expect_equal("s_axil_bresp_o", 32'(resp), 32'(RESP_SLVERR));
        read_reg(4'h2, 0, rd_word, resp);
        expect_equal("s_axil_rresp_o", 32'(resp), 32'(RESP_SLVERR));
        expect_equal("s_axil_rdata_o", rd_word, 32'd0);

        // stalled read pops once
        send_symbols(3, 1'b1);
        read_reg(REG_DATA, 6, rd_word, resp);
        expect_equal("s_axil_rdata_o", rd_word, 32'(model_q.pop_front()));
        check_reg("level", REG_LEVEL, 32'(model_q.size()));
        drain_and_check();

        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verification
logic/llr_pkg.sv
logic/llr_demap.sv
logic/llr_fifo.sv
logic/llr_axil_regs.sv
logic/pbch_llr_capture.sv
verification/pbch_llr_capture_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the PBCH LLR capture testbench with Verilator.
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE=sim.log

mkdir -p "$BUILD_DIR"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module pbch_llr_capture_tb \
    -Mdir "$BUILD_DIR/obj_dir" \
    -o sim

"./$BUILD_DIR/obj_dir/sim" > "$LOG_FILE" 2>&1 || true
cat "$LOG_FILE"

if grep -q "TEST RESULT: FAIL" "$LOG_FILE"; then
    exit 1
fi
